//--- hw/bp_config_pkg.sv
// Branch predictor configuration with default table, stack and address sizes
package bp_config_pkg;

    // ########################################
    // Target buffer geometry
    // ########################################
    localparam int BP_WAYS    = 2;   // Ways per set
    localparam int BP_ENTRIES = 64;  // Sets per way

    // ########################################
    // Return stack and address fields
    // ########################################
    localparam int RAS_DEPTH = 4;    // Return addresses kept
    localparam int PC_W      = 32;   // Fetch address width

endpackage

//--- hw/bp_types_pkg.sv
// Branch predictor types for counters, execute results and table entries
package bp_types_pkg;
    import bp_config_pkg::*;

    // 2-bit direction counter, bit 1 set means predict taken
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } ctr_state_e;

    // Metadata carried with a fetch through the pipeline
    typedef ctr_state_e bp_meta_t;

    // One word of resolved branch results from execute
    typedef struct packed {
        logic              branch_ex;               // Result valid
        logic [PC_W-1:0]   pc_ex;                   // Branch address
        logic [PC_W-1:0]   jump_pc;                 // Taken target
        logic [PC_W-1:0]   njump_pc;                // Fall-through address
        logic              branch_taken;
        logic              branch_prediction_used;
        bp_meta_t          branch_ex_metadata;      // Counter predicted with
        logic              is_return_ex;
        logic              is_call_ex;
    } branch_results_t;

    // Tag bank entry
    // The tag keeps the whole word address so the entry format
    // stays the same for any table depth
    typedef struct packed {
        logic              valid;
        logic [PC_W-3:0]   tag;
        logic              use_ras;                 // Target comes from the return stack
        bp_meta_t          metadata;
    } bp_entry_t;

endpackage

//--- hw/branch_predictor_if.sv
// Fetch side to predictor link carrying lookup requests and prediction results
interface branch_predictor_if
    import bp_config_pkg::*;
    import bp_types_pkg::*;
#(
    parameter int WAYS = BP_WAYS
) ();

    // Fetch side
    logic [PC_W-1:0] next_pc;           // Address looked up this edge
    logic            new_mem_request;   // Read strobe
    logic [PC_W-1:0] if_pc;             // Address compared one cycle later

    // Predictor side
    logic [PC_W-1:0] predicted_pc;
    bp_meta_t        metadata;
    logic            use_ras;
    logic [WAYS-1:0] update_way;        // One-hot hit way or zero
    logic            use_prediction;
    logic [PC_W-1:0] branch_flush_pc;

    modport fetch (
        output next_pc, new_mem_request, if_pc,
        input  predicted_pc, metadata, use_ras, update_way, use_prediction,
        input  branch_flush_pc
    );

    modport predictor (
        input  next_pc, new_mem_request, if_pc,
        output predicted_pc, metadata, use_ras, update_way, use_prediction,
        output branch_flush_pc
    );

endinterface

//--- hw/bp_table_ram.sv
// Dual-port table memory with registered read and read-before-write behavior
module bp_table_ram #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 64
) (
    input  logic                              clk,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] write_addr,
    input  logic                              write_en,
    input  logic [DATA_W-1:0]                 write_data,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] read_addr,
    input  logic                              read_en,
    output logic [DATA_W-1:0]                 read_data
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Same-edge read of a written address returns the old word
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];   // Holds when no read is issued
        end
    end

endmodule

//--- hw/branch_predictor.sv
// Set-associative branch target buffer with 2-bit counters and round-robin allocation
module branch_predictor
    import bp_config_pkg::*;
    import bp_types_pkg::*;
#(
    parameter int WAYS    = BP_WAYS,
    parameter int ENTRIES = BP_ENTRIES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    branch_predictor_if.predictor  bp,
    input  branch_results_t        br_results,
    input  logic [WAYS-1:0]        bp_update_way,
    output logic                   ras_ready
);

    localparam int IDX_W = $clog2(ENTRIES > 1 ? ENTRIES : 2);
    localparam int HIT_W = $clog2(WAYS > 1 ? WAYS : 2);

    typedef enum logic {
        st_sweep,   // Clearing tag banks after reset
        st_run
    } sweep_state_e;

    sweep_state_e    state;
    logic [IDX_W-1:0] clear_idx;
    logic             sweeping;

    bp_entry_t        if_entry [WAYS];
    logic [PC_W-1:0]  way_target [WAYS];
    bp_entry_t        ex_entry;
    bp_entry_t        tag_wr_data;
    logic [PC_W-1:0]  new_target;
    ctr_state_e       new_ctr;

    logic [IDX_W-1:0] ex_idx;
    logic [IDX_W-1:0] if_idx;
    logic [IDX_W-1:0] tag_wr_addr;
    logic [WAYS-1:0]  alloc_way;       // One-hot round-robin pointer
    logic [WAYS-1:0]  ex_way;
    logic [WAYS-1:0]  tag_wr_en;
    logic [WAYS-1:0]  tag_matches;
    logic [HIT_W-1:0] hit_way;
    logic             do_update;
    logic             do_alloc;

    // ########################################
    // Post-reset clear sweep
    // ########################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_sweep;
            clear_idx <= '0;
        end else if (state == st_sweep) begin
            clear_idx <= clear_idx + 1'b1;
            if (clear_idx == IDX_W'(ENTRIES - 1)) begin
                state <= st_run;
            end
        end
    end

    assign sweeping  = (state == st_sweep);
    assign ras_ready = ~sweeping;

    // ########################################
    // Update path from execute
    // ########################################
    assign ex_idx    = br_results.pc_ex[2 +: IDX_W];
    assign if_idx    = bp.next_pc[2 +: IDX_W];
    assign do_update = br_results.branch_ex & ~sweeping;   // Updates wait for the sweep
    assign do_alloc  = do_update & ~br_results.branch_prediction_used;

    // Saturating step, unpredicted branches start strong
    always_comb begin
        case (br_results.branch_ex_metadata)
            strong_nt: new_ctr = br_results.branch_taken ? weak_nt  : strong_nt;
            weak_nt:   new_ctr = br_results.branch_taken ? weak_t   : strong_nt;
            weak_t:    new_ctr = br_results.branch_taken ? strong_t : weak_nt;
            default:   new_ctr = br_results.branch_taken ? strong_t : weak_t;
        endcase
        if (!br_results.branch_prediction_used) begin
            new_ctr = br_results.branch_taken ? strong_t : strong_nt;
        end
    end

    assign ex_entry.valid    = 1'b1;
    assign ex_entry.tag      = br_results.pc_ex[PC_W-1:2];
    assign ex_entry.use_ras  = br_results.is_return_ex;
    assign ex_entry.metadata = new_ctr;

    assign new_target = new_ctr[1] ? br_results.jump_pc : br_results.njump_pc;

    assign ex_way = br_results.branch_prediction_used ? bp_update_way : alloc_way;

    // Sweep owns the tag write ports until it ends
    assign tag_wr_en   = sweeping ? {WAYS{1'b1}} : ({WAYS{do_update}} & ex_way);
    assign tag_wr_addr = sweeping ? clear_idx : ex_idx;
    assign tag_wr_data = sweeping ? bp_entry_t'('0) : ex_entry;

    // Pointer moves only on a fresh allocation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_way <= WAYS'(1);
        end else if (do_alloc) begin
            alloc_way <= (alloc_way << 1) | (alloc_way >> (WAYS - 1));
        end
    end

    // ########################################
    // Tag and target banks
    // ########################################
    for (genvar i = 0; i < WAYS; i++) begin : g_way
        bp_table_ram #(
            .DATA_W ($bits(bp_entry_t)),
            .DEPTH  (ENTRIES)
        ) tag_bank_i (
            .clk        (clk),
            .write_addr (tag_wr_addr),
            .write_en   (tag_wr_en[i]),
            .write_data (tag_wr_data),
            .read_addr  (if_idx),
            .read_en    (bp.new_mem_request),
            .read_data  (if_entry[i])
        );

        bp_table_ram #(
            .DATA_W (PC_W),
            .DEPTH  (ENTRIES)
        ) target_bank_i (
            .clk        (clk),
            .write_addr (ex_idx),
            .write_en   (do_update & ex_way[i]),
            .write_data (new_target),
            .read_addr  (if_idx),
            .read_en    (bp.new_mem_request),
            .read_data  (way_target[i])
        );

        assign tag_matches[i] = if_entry[i].valid & (if_entry[i].tag == bp.if_pc[PC_W-1:2]);
    end

    // ########################################
    // Hit detection and prediction outputs
    // ########################################
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (tag_matches[i]) begin
                hit_way = hit_way | HIT_W'(i);
            end
        end
    end

    assign bp.use_prediction  = (|tag_matches) & ~sweeping;
    assign bp.update_way      = tag_matches & {WAYS{~sweeping}};
    assign bp.predicted_pc    = way_target[hit_way];
    assign bp.metadata        = if_entry[hit_way].metadata;
    assign bp.use_ras         = if_entry[hit_way].use_ras;

    assign bp.branch_flush_pc = br_results.branch_taken ? br_results.jump_pc
                                                        : br_results.njump_pc;

endmodule

//--- hw/return_stack.sv
// Circular return address stack pushed by resolved calls and popped by returns
module return_stack
    import bp_config_pkg::*;
#(
    parameter int DEPTH = RAS_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  logic            pop,
    input  logic [PC_W-1:0] push_addr,
    output logic [PC_W-1:0] top_addr
);

    localparam int PTR_W = $clog2(DEPTH > 1 ? DEPTH : 2);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PC_W-1:0]  stack [DEPTH];
    logic [PTR_W-1:0] ptr;          // Slot of the most recent address
    logic [PTR_W-1:0] ptr_inc;
    logic [PTR_W-1:0] ptr_dec;
    logic [CNT_W-1:0] count;        // Live entries

    assign ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    assign ptr_dec = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

    // Full stack wraps onto the oldest slot
    always_ff @(posedge clk) begin
        if (push) begin
            stack[ptr_inc] <= push_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin   // Push wins over a same-cycle pop
            ptr <= ptr_inc;
            if (count != CNT_W'(DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop && count != '0) begin
            ptr   <= ptr_dec;
            count <= count - 1'b1;
        end
    end

    // Empty stack reads zero
    assign top_addr = (count == '0) ? '0 : stack[ptr];

endmodule

//--- hw/branch_predict_top.sv
// Branch prediction top level joining the target buffer and the return stack
module branch_predict_top
    import bp_config_pkg::*;
    import bp_types_pkg::*;
#(
    parameter int WAYS    = BP_WAYS,
    parameter int ENTRIES = BP_ENTRIES,
    parameter int DEPTH   = RAS_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,

    // Fetch lookup
    input  logic [PC_W-1:0] next_pc,
    input  logic            new_mem_request,
    input  logic [PC_W-1:0] if_pc,

    // Execute results
    input  logic            branch_ex,
    input  logic [PC_W-1:0] pc_ex,
    input  logic [PC_W-1:0] jump_pc,
    input  logic [PC_W-1:0] njump_pc,
    input  logic            branch_taken,
    input  logic            branch_prediction_used,
    input  bp_meta_t        branch_ex_metadata,
    input  logic [WAYS-1:0] bp_update_way,
    input  logic            is_return_ex,
    input  logic            is_call_ex,

    // Prediction
    output logic            use_prediction,
    output logic [PC_W-1:0] predicted_pc,
    output bp_meta_t        metadata,
    output logic [WAYS-1:0] update_way,
    output logic [PC_W-1:0] branch_flush_pc,
    output logic            ready
);

    branch_results_t br_results;
    logic [PC_W-1:0] ras_top;
    logic            ras_push;
    logic            ras_pop;

    branch_predictor_if #(.WAYS(WAYS)) bp_if ();

    // ########################################
    // Fetch side of the interface
    // ########################################
    assign bp_if.next_pc         = next_pc;
    assign bp_if.new_mem_request = new_mem_request;
    assign bp_if.if_pc           = if_pc;

    assign use_prediction  = bp_if.use_prediction;
    assign metadata        = bp_if.metadata;
    assign update_way      = bp_if.update_way;
    assign branch_flush_pc = bp_if.branch_flush_pc;

    // Returns take their target from the stack
    assign predicted_pc = bp_if.use_ras ? ras_top : bp_if.predicted_pc;

    // ########################################
    // Execute results
    // ########################################
    assign br_results.branch_ex              = branch_ex;
    assign br_results.pc_ex                  = pc_ex;
    assign br_results.jump_pc                = jump_pc;
    assign br_results.njump_pc               = njump_pc;
    assign br_results.branch_taken           = branch_taken;
    assign br_results.branch_prediction_used = branch_prediction_used;
    assign br_results.branch_ex_metadata     = branch_ex_metadata;
    assign br_results.is_return_ex           = is_return_ex;
    assign br_results.is_call_ex             = is_call_ex;

    assign ras_push = branch_ex & is_call_ex;     // Return address is the fall-through
    assign ras_pop  = branch_ex & is_return_ex;

    branch_predictor #(
        .WAYS    (WAYS),
        .ENTRIES (ENTRIES)
    ) predictor_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .bp            (bp_if.predictor),
        .br_results    (br_results),
        .bp_update_way (bp_update_way),
        .ras_ready     (ready)
    );

    return_stack #(
        .DEPTH (DEPTH)
    ) ras_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (njump_pc),
        .top_addr  (ras_top)
    );

endmodule

//--- sim/tb_branch_predict_top.sv
// Table-driven testbench for the branch prediction top level with update and lookup steps
module tb_branch_predict_top
    import bp_config_pkg::*;
    import bp_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        int                 test;
        bit                 lookup;         // Lookup step, else update step
        logic [PC_W-1:0]    pc;
        logic [PC_W-1:0]    jump;
        logic [PC_W-1:0]    njump;
        logic               taken;
        logic               used;
        logic               is_ret;
        logic               is_call;
        ctr_state_e         meta;
        logic [BP_WAYS-1:0] upd_way;
        logic               exp_hit;
        logic [PC_W-1:0]    exp_pc;         // Predicted target, or flush address on updates
        ctr_state_e         exp_meta;
        logic [BP_WAYS-1:0] exp_way;
    } step_t;

    logic               clk;
    logic               rst_n;
    logic [PC_W-1:0]    next_pc;
    logic               new_mem_request;
    logic [PC_W-1:0]    if_pc;
    logic               branch_ex;
    logic [PC_W-1:0]    pc_ex;
    logic [PC_W-1:0]    jump_pc;
    logic [PC_W-1:0]    njump_pc;
    logic               branch_taken;
    logic               branch_prediction_used;
    bp_meta_t           branch_ex_metadata;
    logic [BP_WAYS-1:0] bp_update_way;
    logic               is_return_ex;
    logic               is_call_ex;
    logic               use_prediction;
    logic [PC_W-1:0]    predicted_pc;
    bp_meta_t           metadata;
    logic [BP_WAYS-1:0] update_way;
    logic [PC_W-1:0]    branch_flush_pc;
    logic               ready;

    step_t              steps [$];
    logic [BP_WAYS-1:0] alloc_model;      // Expected round-robin pointer
    logic [31:0]        lfsr_state = 32'hde3b_0211;
    int                 errors [1:6];
    string              test_name [1:6] = '{"miss after reset", "allocate taken branch",
        "counter stepping", "round-robin eviction", "return stack target", "not-taken allocate"};

    branch_predict_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ########################################
    // Stimulus helpers
    // ########################################
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};   // One LFSR step per bit
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    task automatic add_update(input int test, input logic [PC_W-1:0] pc, jump, njump,
                              input logic taken, used, input ctr_state_e meta,
                              input logic [BP_WAYS-1:0] upd, input logic is_ret, is_call,
                              output logic [BP_WAYS-1:0] way);
        step_t s;
        s.test = test;
        s.lookup = 1'b0;
        s.pc = pc;
        s.jump = jump;
        s.njump = njump;
        s.taken = taken;
        s.used = used;
        s.meta = meta;
        s.upd_way = upd;
        s.is_ret = is_ret;
        s.is_call = is_call;
        s.exp_pc = taken ? jump : njump;
        way = used ? upd : alloc_model;
        if (!used) begin
            alloc_model = {alloc_model[BP_WAYS-2:0], alloc_model[BP_WAYS-1]};
        end
        steps.push_back(s);
    endtask

    task automatic add_lookup(input int test, input logic [PC_W-1:0] pc, input logic hit,
                              input logic [PC_W-1:0] exp_pc, input ctr_state_e exp_meta,
                              input logic [BP_WAYS-1:0] exp_way);
        step_t s;
        s.test = test;
        s.lookup = 1'b1;
        s.pc = pc;
        s.exp_hit = hit;
        s.exp_pc = exp_pc;
        s.exp_meta = exp_meta;
        s.exp_way = exp_way;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [BP_WAYS-1:0] w;
        logic [BP_WAYS-1:0] way4 [3];
        logic [PC_W-1:0]    pc4 [3];
        logic [PC_W-1:0]    tgt4 [3];
        logic [31:0]        r;
        alloc_model = BP_WAYS'(1);
        add_lookup(1, 32'h0000_1000, 1'b0, '0, strong_nt, '0);
        add_lookup(1, 32'h0000_2abc, 1'b0, '0, strong_nt, '0);
        add_update(2, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 1, 0, strong_nt, '0, 0, 0, w);
        add_lookup(2, 32'h0000_0104, 1'b1, 32'h0000_0800, strong_t, w);
        add_update(3, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 0, 1, strong_t, w, 0, 0, w);
        add_lookup(3, 32'h0000_0104, 1'b1, 32'h0000_0800, weak_t, w);
        add_update(3, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 0, 1, weak_t, w, 0, 0, w);
        add_lookup(3, 32'h0000_0104, 1'b1, 32'h0000_0108, weak_nt, w);
        add_update(3, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 1, 1, weak_nt, w, 0, 0, w);
        add_update(3, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 1, 1, weak_t, w, 0, 0, w);
        add_update(3, 32'h0000_0104, 32'h0000_0800, 32'h0000_0108, 1, 1, strong_t, w, 0, 0, w);
        add_lookup(3, 32'h0000_0104, 1'b1, 32'h0000_0800, strong_t, w);
        for (int k = 0; k < 3; k++) begin
            r = take_bits(22);
            pc4[k] = {r[21:0], 2'(k), 8'h14};   // Distinct tags, all in set 5
            r = take_bits(30);
            tgt4[k] = {r[29:0], 2'b00};
            add_update(4, pc4[k], tgt4[k], pc4[k] + 4, 1, 0, strong_nt, '0, 0, 0, way4[k]);
        end
        add_lookup(4, pc4[0], 1'b0, '0, strong_nt, '0);
        add_lookup(4, pc4[1], 1'b1, tgt4[1], strong_t, way4[1]);
        add_lookup(4, pc4[2], 1'b1, tgt4[2], strong_t, way4[2]);
        // The return resolving pops the second call, so the first one is on top
        add_update(5, 32'h0000_0200, 32'h0000_3000, 32'h0000_0204, 1, 0, strong_nt, '0, 0, 1, w);
        add_update(5, 32'h0000_0310, 32'h0000_3400, 32'h0000_0314, 1, 0, strong_nt, '0, 0, 1, w);
        add_update(5, 32'h0000_0420, 32'h0000_0314, 32'h0000_0424, 1, 0, strong_nt, '0, 1, 0, w);
        add_lookup(5, 32'h0000_0420, 1'b1, 32'h0000_0204, strong_t, w);
        add_update(6, 32'h0000_0530, 32'h0000_0a00, 32'h0000_0534, 0, 0, strong_nt, '0, 0, 0, w);
        add_lookup(6, 32'h0000_0530, 1'b1, 32'h0000_0534, strong_nt, w);
    endtask

    // ########################################
    // Step execution and checks
    // ########################################
    task automatic report_error(input int test, input string what,
                                input logic [PC_W-1:0] got, exp);
        $display("Error at %0d ns: test %0d %s is %h, expected %h", $time, test, what, got, exp);
        errors[test]++;
    endtask

    task automatic apply_step(input step_t s);
        if (s.lookup) begin
            next_pc = s.pc;
            new_mem_request = 1'b1;
            @(negedge clk);
            new_mem_request = 1'b0;
            next_pc = ~s.pc;                 // Other set, the RAM must hold its last read
            if_pc = s.pc;                    // Compared one cycle after the read
            @(negedge clk);
            if (use_prediction !== s.exp_hit) begin
                report_error(s.test, "use_prediction", use_prediction, s.exp_hit);
            end
            if (update_way !== s.exp_way) begin
                report_error(s.test, "update_way", update_way, s.exp_way);
            end
            if (s.exp_hit && predicted_pc !== s.exp_pc) begin
                report_error(s.test, "predicted_pc", predicted_pc, s.exp_pc);
            end
            if (s.exp_hit && metadata !== s.exp_meta) begin
                report_error(s.test, "metadata", metadata, s.exp_meta);
            end
        end else begin
            pc_ex = s.pc;
            jump_pc = s.jump;
            njump_pc = s.njump;
            branch_taken = s.taken;
            branch_prediction_used = s.used;
            branch_ex_metadata = s.meta;
            bp_update_way = s.upd_way;
            is_return_ex = s.is_ret;
            is_call_ex = s.is_call;
            branch_ex = 1'b1;
            @(negedge clk);
            if (branch_flush_pc !== s.exp_pc) begin
                report_error(s.test, "branch_flush_pc", branch_flush_pc, s.exp_pc);
            end
            branch_ex = 1'b0;
        end
    endtask

    initial begin
        int wait_cycles;
        int total_errors;
        int failed_tests;
        rst_n = 1'b0;
        next_pc = '0;
        new_mem_request = 1'b0;
        if_pc = '0;
        branch_ex = 1'b0;
        pc_ex = '0;
        jump_pc = '0;
        njump_pc = '0;
        branch_taken = 1'b0;
        branch_prediction_used = 1'b0;
        branch_ex_metadata = strong_nt;
        bp_update_way = '0;
        is_return_ex = 1'b0;
        is_call_ex = 1'b0;
        build_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait_cycles = 0;
        while (ready !== 1'b1 && wait_cycles < 200) begin   // Tag clear sweep
            if (use_prediction !== 1'b0) begin   // No prediction before the sweep ends
                report_error(1, "use_prediction during sweep", use_prediction, 1'b0);
            end
            if (update_way !== '0) begin
                report_error(1, "update_way during sweep", update_way, '0);
            end
            @(negedge clk);
            wait_cycles++;
        end
        if (ready !== 1'b1) begin
            $display("Timeout: ready did not rise within 200 cycles after reset");
            $display("Test failed");
            $finish;
        end else begin
            total_errors = 0;
            failed_tests = 0;
            for (int i = 0; i < steps.size(); i++) begin
                apply_step(steps[i]);
                if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                    $display("Test %0d %s: %s (%0d errors)", steps[i].test,
                             test_name[steps[i].test],
                             errors[steps[i].test] == 0 ? "ok" : "FAILED",
                             errors[steps[i].test]);
                    total_errors += errors[steps[i].test];
                    failed_tests += (errors[steps[i].test] != 0);
                end
            end
            $display("Summary: 6 tests, %0d ok, %0d failing, %0d errors",
                     6 - failed_tests, failed_tests, total_errors);
            if (total_errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/bp_config_pkg.sv
hw/bp_types_pkg.sv
hw/branch_predictor_if.sv
hw/bp_table_ram.sv
hw/branch_predictor.sv
hw/return_stack.sv
hw/branch_predict_top.sv
sim/tb_branch_predict_top.sv

//--- Bender.yml
package:
  name: branch_predict

sources:
  - hw/bp_config_pkg.sv
  - hw/bp_types_pkg.sv
  - hw/branch_predictor_if.sv
  - hw/bp_table_ram.sv
  - hw/branch_predictor.sv
  - hw/return_stack.sv
  - hw/branch_predict_top.sv
  - target: simulation
    files:
      - sim/tb_branch_predict_top.sv
